// File: hw/rv_control.sv
`default_nettype none

module rv_control #(
    parameter logic [rv_pkg::xlen-1:0] RESET_PC = 32'h0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mem_ack,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    input  rv_pkg::decoded_t        dec,
    input  logic [rv_pkg::xlen-1:0] alu_result,
    input  logic [rv_pkg::xlen-1:0] next_pc,
    input  logic [rv_pkg::xlen-1:0] store_data,
    output logic                    mem_valid,
    output rv_pkg::mem_req_t        mem_req,
    output logic [rv_pkg::xlen-1:0] inst,
    output logic [rv_pkg::xlen-1:0] pc,
    output logic [rv_pkg::xlen-1:0] load_data,
    output logic                    rf_we,
    output logic                    halted
);

    typedef enum logic [2:0] {
        fetch_req,
        fetch_wait_low,
        exec,
        data_req,
        data_wait_low,
        writeback,
        halt
    } state_t;

    state_t state;
    logic   is_mem;
    logic   is_stop;
    logic   writes_rd;

    assign is_mem    = (dec.cls == rv_pkg::cls_load) || (dec.cls == rv_pkg::cls_store);
    assign is_stop   = (dec.cls == rv_pkg::cls_system) || (dec.cls == rv_pkg::cls_illegal);
    assign writes_rd = dec.cls inside {rv_pkg::cls_op, rv_pkg::cls_op_imm, rv_pkg::cls_lui,
                                       rv_pkg::cls_auipc, rv_pkg::cls_jal, rv_pkg::cls_jalr};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= fetch_req;
            mem_valid <= 1'b0;
            pc        <= RESET_PC;
        end else begin
            case (state)
                fetch_req: begin
                    if (!mem_valid && !mem_ack) begin  // first fetch after reset
                        mem_valid <= 1'b1;
                    end else if (mem_valid && mem_ack) begin
                        mem_valid <= 1'b0;
                        state     <= fetch_wait_low;
                    end
                end
                fetch_wait_low: if (!mem_ack) state <= exec;
                exec: begin
                    if (is_stop) begin
                        state <= halt;
                    end else if (is_mem) begin
                        mem_valid <= 1'b1;
                        state     <= data_req;
                    end else begin
                        // ALU and jump retire here, next fetch starts at once
                        pc        <= next_pc;
                        mem_valid <= 1'b1;
                        state     <= fetch_req;
                    end
                end
                data_req: begin
                    if (mem_ack) begin
                        mem_valid <= 1'b0;
                        state     <= data_wait_low;
                    end
                end
                data_wait_low: if (!mem_ack) state <= writeback;
                writeback: begin
                    pc        <= next_pc;
                    mem_valid <= 1'b1;
                    state     <= fetch_req;
                end
                default: state <= halt;     // stays here until reset
            endcase
        end
    end

    // instruction and load registers
    always_ff @(posedge clk) begin
        if (state == fetch_req && mem_valid && mem_ack) begin
            inst <= mem_rdata;
        end
        if (state == data_req && mem_ack) begin
            load_data <= mem_rdata;
        end
    end

    always_comb begin
        mem_req.addr  = (state == data_req) ? alu_result : pc;
        mem_req.wdata = store_data;
        mem_req.we    = (state == data_req) && (dec.cls == rv_pkg::cls_store);
    end

    assign rf_we  = (state == exec && writes_rd) ||
                    (state == writeback && dec.cls == rv_pkg::cls_load);
    assign halted = (state == halt);

endmodule

`default_nettype wire

// File: hw/rv_core.sv
`default_nettype none

module rv_core #(
    parameter logic [rv_pkg::xlen-1:0] RESET_PC = 32'h0
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    mem_ack,
    input  logic [rv_pkg::xlen-1:0] mem_rdata,
    output logic                    mem_valid,
    output rv_pkg::mem_req_t        mem_req,
    output logic                    halted
);

    rv_pkg::decoded_t        dec;
    logic [rv_pkg::xlen-1:0] inst;
    logic [rv_pkg::xlen-1:0] pc;
    logic [rv_pkg::xlen-1:0] load_data;
    logic [rv_pkg::xlen-1:0] rdata1;
    logic [rv_pkg::xlen-1:0] rdata2;     // also the store word
    logic [rv_pkg::xlen-1:0] alu_result;
    logic [rv_pkg::xlen-1:0] next_pc;
    logic [rv_pkg::xlen-1:0] wb_data;
    logic                    rf_we;

    rv_control #(
        .RESET_PC(RESET_PC)
    ) u_control (
        .clk       (clk),
        .reset     (reset),
        .mem_ack   (mem_ack),
        .mem_rdata (mem_rdata),
        .dec       (dec),
        .alu_result(alu_result),
        .next_pc   (next_pc),
        .store_data(rdata2),
        .mem_valid (mem_valid),
        .mem_req   (mem_req),
        .inst      (inst),
        .pc        (pc),
        .load_data (load_data),
        .rf_we     (rf_we),
        .halted    (halted)
    );

    rv_decoder u_decoder (
        .inst(inst),
        .dec (dec)
    );

    rv_regfile u_regfile (
        .clk   (clk),
        .we    (rf_we),
        .waddr (dec.rd),
        .raddr1(dec.rs1),
        .raddr2(dec.rs2),
        .wdata (wb_data),
        .rdata1(rdata1),
        .rdata2(rdata2)
    );

    rv_execute u_execute (
        .dec       (dec),
        .src1      (rdata1),
        .src2      (rdata2),
        .pc        (pc),
        .load_data (load_data),
        .alu_result(alu_result),
        .next_pc   (next_pc),
        .wb_data   (wb_data)
    );

endmodule

`default_nettype wire

// File: hw/rv_decoder.sv
`default_nettype none

module rv_decoder (
    input  logic [rv_pkg::xlen-1:0] inst,
    output rv_pkg::decoded_t        dec
);

    logic [6:0] funct7;
    logic [2:0] funct3;
    logic       alt_ok;     // funct7 legal for R-type and shift forms

    assign funct7 = inst[31:25];
    assign funct3 = inst[14:12];
    assign alt_ok = (funct7 == 7'h00) || (funct7 == 7'h20 && funct3 inside {3'b000, 3'b101});

    always_comb begin
        dec.funct3 = funct3;
        dec.rd     = inst[11:7];
        dec.rs1    = inst[19:15];
        dec.rs2    = inst[24:20];

        case (rv_pkg::opcode_t'(inst[6:0]))
            rv_pkg::opc_op:
                dec.cls = alt_ok ? rv_pkg::cls_op : rv_pkg::cls_illegal;
            rv_pkg::opc_op_imm:
                dec.cls = (funct3 inside {3'b001, 3'b101} && !alt_ok) ?
                          rv_pkg::cls_illegal : rv_pkg::cls_op_imm;
            rv_pkg::opc_load:   // word access only
                dec.cls = (funct3 == 3'b010) ? rv_pkg::cls_load : rv_pkg::cls_illegal;
            rv_pkg::opc_store:
                dec.cls = (funct3 == 3'b010) ? rv_pkg::cls_store : rv_pkg::cls_illegal;
            rv_pkg::opc_branch:
                dec.cls = (funct3 inside {3'b010, 3'b011}) ?
                          rv_pkg::cls_illegal : rv_pkg::cls_branch;
            rv_pkg::opc_lui:    dec.cls = rv_pkg::cls_lui;
            rv_pkg::opc_auipc:  dec.cls = rv_pkg::cls_auipc;
            rv_pkg::opc_jal:    dec.cls = rv_pkg::cls_jal;
            rv_pkg::opc_jalr:
                dec.cls = (funct3 == 3'b000) ? rv_pkg::cls_jalr : rv_pkg::cls_illegal;
            rv_pkg::opc_system:
                dec.cls = (inst == rv_pkg::ebreak_word) ? rv_pkg::cls_system : rv_pkg::cls_illegal;
            default:            dec.cls = rv_pkg::cls_illegal;
        endcase

        // immediate format follows the class
        case (dec.cls)
            rv_pkg::cls_store:
                dec.imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            rv_pkg::cls_branch:
                dec.imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            rv_pkg::cls_lui, rv_pkg::cls_auipc:
                dec.imm = {inst[31:12], 12'b0};
            rv_pkg::cls_jal:
                dec.imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default:
                dec.imm = {{20{inst[31]}}, inst[31:20]};    // I-type
        endcase

        // address and link arithmetic all use add
        dec.alu_op = rv_pkg::alu_add;
        if (dec.cls == rv_pkg::cls_op || dec.cls == rv_pkg::cls_op_imm) begin
            case (funct3)
                3'b000: dec.alu_op = (dec.cls == rv_pkg::cls_op && inst[30]) ?
                                     rv_pkg::alu_sub : rv_pkg::alu_add;
                3'b001: dec.alu_op = rv_pkg::alu_sll;
                3'b010: dec.alu_op = rv_pkg::alu_slt;
                3'b011: dec.alu_op = rv_pkg::alu_sltu;
                3'b100: dec.alu_op = rv_pkg::alu_xor;
                3'b101: dec.alu_op = inst[30] ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                3'b110: dec.alu_op = rv_pkg::alu_or;
                default: dec.alu_op = rv_pkg::alu_and;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/rv_execute.sv
`default_nettype none

module rv_execute (
    input  rv_pkg::decoded_t        dec,
    input  logic [rv_pkg::xlen-1:0] src1,
    input  logic [rv_pkg::xlen-1:0] src2,
    input  logic [rv_pkg::xlen-1:0] pc,
    input  logic [rv_pkg::xlen-1:0] load_data,
    output logic [rv_pkg::xlen-1:0] alu_result,
    output logic [rv_pkg::xlen-1:0] next_pc,
    output logic [rv_pkg::xlen-1:0] wb_data
);

    logic [rv_pkg::xlen-1:0] alu_a;
    logic [rv_pkg::xlen-1:0] alu_b;
    logic [rv_pkg::xlen-1:0] link_addr;
    logic [4:0]              shamt;
    logic                    taken;

    assign link_addr = pc + 32'd4;
    assign shamt     = alu_b[4:0];

    // operand select
    always_comb begin
        case (dec.cls)
            rv_pkg::cls_auipc, rv_pkg::cls_jal, rv_pkg::cls_branch: begin
                alu_a = pc;
                alu_b = dec.imm;
            end
            rv_pkg::cls_lui: begin
                alu_a = '0;
                alu_b = dec.imm;
            end
            rv_pkg::cls_op: begin
                alu_a = src1;
                alu_b = src2;
            end
            default: begin      // I-type and S-type
                alu_a = src1;
                alu_b = dec.imm;
            end
        endcase
    end

    always_comb begin
        case (dec.alu_op)
            rv_pkg::alu_sub:  alu_result = alu_a - alu_b;
            rv_pkg::alu_sll:  alu_result = alu_a << shamt;
            rv_pkg::alu_slt:  alu_result = {31'b0, $signed(alu_a) < $signed(alu_b)};
            rv_pkg::alu_sltu: alu_result = {31'b0, alu_a < alu_b};
            rv_pkg::alu_xor:  alu_result = alu_a ^ alu_b;
            rv_pkg::alu_srl:  alu_result = alu_a >> shamt;
            rv_pkg::alu_sra:  alu_result = $unsigned($signed(alu_a) >>> shamt);
            rv_pkg::alu_or:   alu_result = alu_a | alu_b;
            rv_pkg::alu_and:  alu_result = alu_a & alu_b;
            default:          alu_result = alu_a + alu_b;
        endcase
    end

    // branch compare works on the raw register operands
    always_comb begin
        case (rv_pkg::branch_fn_t'(dec.funct3))
            rv_pkg::br_eq:  taken = (src1 == src2);
            rv_pkg::br_ne:  taken = (src1 != src2);
            rv_pkg::br_lt:  taken = ($signed(src1) < $signed(src2));
            rv_pkg::br_ge:  taken = ($signed(src1) >= $signed(src2));
            rv_pkg::br_ltu: taken = (src1 < src2);
            rv_pkg::br_geu: taken = (src1 >= src2);
            default:        taken = 1'b0;
        endcase
    end

    always_comb begin
        next_pc = link_addr;
        case (dec.cls)
            rv_pkg::cls_jal:    next_pc = alu_result;
            rv_pkg::cls_jalr:   next_pc = {alu_result[rv_pkg::xlen-1:1], 1'b0};
            rv_pkg::cls_branch: next_pc = taken ? alu_result : link_addr;
            default:            next_pc = link_addr;
        endcase
    end

    always_comb begin
        case (dec.cls)
            rv_pkg::cls_jal, rv_pkg::cls_jalr: wb_data = link_addr;
            rv_pkg::cls_load:                  wb_data = load_data;
            default:                           wb_data = alu_result;
        endcase
    end

endmodule

`default_nettype wire

// File: hw/rv_pkg.sv
`default_nettype none

package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    // ebreak, the only system instruction the core accepts
    localparam logic [xlen-1:0] ebreak_word = 32'h0010_0073;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        opc_op     = 7'b0110011,
        opc_op_imm = 7'b0010011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_lui    = 7'b0110111,
        opc_auipc  = 7'b0010111,
        opc_jal    = 7'b1101111,
        opc_jalr   = 7'b1100111,
        opc_system = 7'b1110011
    } opcode_t;

    typedef enum logic [3:0] {
        cls_op,
        cls_op_imm,
        cls_load,
        cls_store,
        cls_branch,
        cls_lui,
        cls_auipc,
        cls_jal,
        cls_jalr,
        cls_system,
        cls_illegal     // anything we do not run, halts the core
    } inst_class_t;

    typedef enum logic [3:0] {
        alu_add,
        alu_sub,
        alu_sll,
        alu_slt,
        alu_sltu,
        alu_xor,
        alu_srl,
        alu_sra,
        alu_or,
        alu_and
    } alu_op_t;

    // branch funct3 encodings
    typedef enum logic [2:0] {
        br_eq  = 3'b000,
        br_ne  = 3'b001,
        br_lt  = 3'b100,
        br_ge  = 3'b101,
        br_ltu = 3'b110,
        br_geu = 3'b111
    } branch_fn_t;

    typedef struct packed {
        inst_class_t           cls;
        alu_op_t               alu_op;
        logic [2:0]            funct3;
        logic [reg_addr_w-1:0] rd;
        logic [reg_addr_w-1:0] rs1;
        logic [reg_addr_w-1:0] rs2;
        logic [xlen-1:0]       imm;     // already sign extended
    } decoded_t;

    // one shared bus for fetch and data
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            we;
    } mem_req_t;

endpackage

`default_nettype wire

// File: hw/rv_regfile.sv
`default_nettype none

module rv_regfile (
    input  logic                          clk,
    input  logic                          we,
    input  logic [rv_pkg::reg_addr_w-1:0] waddr,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr1,
    input  logic [rv_pkg::reg_addr_w-1:0] raddr2,
    input  logic [rv_pkg::xlen-1:0]       wdata,
    output logic [rv_pkg::xlen-1:0]       rdata1,
    output logic [rv_pkg::xlen-1:0]       rdata2
);

    logic [rv_pkg::xlen-1:0] regs [2**rv_pkg::reg_addr_w];

    always_ff @(posedge clk) begin
        if (we && waddr != '0) begin    // x0 is never written
            regs[waddr] <= wdata;
        end
    end

    // x0 entry is never initialised, so mask it on read
    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// File: project.f
hw/rv_pkg.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_execute.sv
hw/rv_control.sv
hw/rv_core.sv
tb/tb_clock.sv
tb/rv_core_assertions.sv
tb/rv_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the rv_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module rv_core_tb -f project.f -o rv_core_sim

./obj_dir/rv_core_sim | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
fi
exit 1

// File: tb/rv_core_assertions.sv
`default_nettype none

module rv_core_assertions (
    input logic             clk,
    input logic             reset,
    input logic             mem_valid,
    input logic             mem_ack,
    input rv_pkg::mem_req_t mem_req,
    input logic             halted
);

    timeunit 1ns;
    timeprecision 100ps;

    int fail_count = 0;     // assertion failures so far

    // request held steady until the memory answers
    req_stable: assert property (@(posedge clk) disable iff (reset)
        mem_valid && !mem_ack |=> $stable(mem_req))
        else begin
            $error("bus request changed while waiting for ack");
            fail_count++;
        end

    // four-phase: no new request before ack has dropped
    no_early_valid: assert property (@(posedge clk) disable iff (reset)
        $rose(mem_valid) |-> !mem_ack)
        else begin
            $error("mem_valid raised while mem_ack still high");
            fail_count++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (reset)
        halted |=> halted)
        else begin
            $error("halted dropped without reset");
            fail_count++;
        end

endmodule

bind rv_control rv_core_assertions u_assertions (
    .clk      (clk),
    .reset    (reset),
    .mem_valid(mem_valid),
    .mem_ack  (mem_ack),
    .mem_req  (mem_req),
    .halted   (halted)
);

`default_nettype wire

// File: tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int max_tests   = 32;
    localparam int timeout_cyc = 2000;
    localparam logic [31:0] ebreak = 32'h0010_0073;

    logic                    clk;
    logic                    reset;
    logic                    mem_ack = 1'b0;
    logic [31:0]             mem_rdata = '0;
    logic                    mem_valid;
    rv_pkg::mem_req_t        mem_req;
    logic                    halted;

    logic [31:0] mem [256];
    logic [31:0] last_addr;
    logic [31:0] last_data;
    int          delay;

    string       test_name [max_tests];
    logic [31:0] progs [max_tests][8];
    logic [31:0] exp_addr [max_tests];
    logic [31:0] exp_data [max_tests];
    logic [31:0] prog_buf [$];
    int          num_tests = 0;
    int          errors = 0;
    int          failed_tests = 0;

    tb_clock u_clock (.clk(clk));

    rv_core #(
        .RESET_PC(32'h0)
    ) uut (
        .clk      (clk),
        .reset    (reset),
        .mem_ack  (mem_ack),
        .mem_rdata(mem_rdata),
        .mem_valid(mem_valid),
        .mem_req  (mem_req),
        .halted   (halted)
    );

    // memory model, 0 to 3 idle cycles before each ack
    always @(posedge clk) begin
        if (reset) begin
            mem_ack   <= 1'b0;
            last_addr <= 32'hFFFF_FFFF;    // no store seen yet
            last_data <= 32'hFFFF_FFFF;
            delay     <= $urandom % 4;
        end else if (mem_ack) begin
            if (!mem_valid) begin
                mem_ack <= 1'b0;
                delay   <= $urandom % 4;
            end
        end else if (mem_valid) begin
            if (delay == 0) begin
                mem_ack <= 1'b1;
                if (mem_req.we) begin
                    mem[mem_req.addr[9:2]] <= mem_req.wdata;
                    last_addr <= mem_req.addr;
                    last_data <= mem_req.wdata;
                end else begin
                    mem_rdata <= mem[mem_req.addr[9:2]];
                end
            end else begin
                delay <= delay - 1;
            end
        end
    end

    // instruction encoders
    function automatic logic [31:0] i_type(logic [6:0] opc, int f3, int rd, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] addi(int rd, int rs1, int imm);
        return i_type(rv_pkg::opc_op_imm, 0, rd, rs1, imm);
    endfunction

    function automatic logic [31:0] alu_rr(int f7, int f3, int rd, int rs1, int rs2);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], rv_pkg::opc_op};
    endfunction

    function automatic logic [31:0] sw_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], rv_pkg::opc_store};
    endfunction

    function automatic logic [31:0] branch(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                rv_pkg::opc_branch};
    endfunction

    function automatic logic [31:0] u_type(logic [6:0] opc, int rd, int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] jal_to(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], rv_pkg::opc_jal};
    endfunction

    task automatic add_test(input string name, input logic [31:0] data);
        test_name[num_tests] = name;
        exp_addr[num_tests]  = 32'h100;
        exp_data[num_tests]  = data;
        for (int k = 0; k < 8; k++) begin
            progs[num_tests][k] = (k < prog_buf.size()) ? prog_buf[k] : ebreak;
        end
        prog_buf.delete();
        num_tests++;
    endtask

    // x3 gets +1 if the first branch falls through, +2 if the second does
    task automatic branch_test(input string name, input int f3, input bit same, input int exp);
        prog_buf = '{addi(1, 0, -2), addi(3, 0, 0), branch(f3, 1, 0, 8), addi(3, 3, 1),
                     branch(f3, same ? 1 : 0, 1, 8), addi(3, 3, 2), sw_word(3, 0, 'h100)};
        add_test(name, exp);
    endtask

    task automatic build_table();
        prog_buf = '{addi(1, 0, 100), addi(2, 0, -7), alu_rr(0, 0, 3, 1, 2),
                     alu_rr('h20, 0, 4, 3, 2), alu_rr(0, 0, 5, 3, 4), sw_word(5, 0, 'h100)};
        add_test("alu_add_sub", 32'd193);
        prog_buf = '{addi(1, 0, -256), i_type(rv_pkg::opc_op_imm, 1, 2, 1, 4), addi(3, 0, 8),
                     alu_rr('h20, 5, 4, 2, 3), alu_rr(0, 4, 5, 4, 1), sw_word(5, 0, 'h100)};
        add_test("alu_shift", 32'h0000_00F0);
        prog_buf = '{addi(1, 0, -1), addi(2, 0, 1), alu_rr(0, 2, 3, 1, 2), alu_rr(0, 3, 4, 2, 1),
                     i_type(rv_pkg::opc_op_imm, 1, 4, 4, 4), alu_rr(0, 6, 5, 3, 4),
                     sw_word(5, 0, 'h100)};
        add_test("alu_compare", 32'h11);
        prog_buf = '{u_type(rv_pkg::opc_lui, 1, 'h12345), addi(1, 1, 'h678), addi(2, 0, 'hF0),
                     alu_rr(0, 7, 3, 1, 2), alu_rr(0, 6, 4, 3, 2), alu_rr(0, 4, 5, 4, 1),
                     sw_word(5, 0, 'h100)};
        add_test("alu_logic", 32'h1234_5688);
        branch_test("beq", 0, 1'b1, 1);
        branch_test("bne", 1, 1'b1, 2);
        branch_test("blt", 4, 1'b0, 2);
        branch_test("bge", 5, 1'b0, 1);
        branch_test("bltu", 6, 1'b0, 1);
        branch_test("bgeu", 7, 1'b0, 2);
        prog_buf = '{addi(5, 0, 7), jal_to(1, 8), addi(5, 0, 99), alu_rr(0, 0, 5, 5, 1),
                     sw_word(5, 0, 'h100)};
        add_test("jal", 32'd15);
        // target 17 has its low bit cleared, lands on 16
        prog_buf = '{addi(2, 0, 17), addi(5, 0, 'h100), i_type(rv_pkg::opc_jalr, 0, 1, 2, 0),
                     addi(5, 0, 99), alu_rr(0, 0, 5, 5, 1), sw_word(5, 0, 'h100)};
        add_test("jalr", 32'h10C);
        prog_buf = '{u_type(rv_pkg::opc_lui, 1, 'hABCDE), sw_word(1, 0, 'h100)};
        add_test("lui", 32'hABCD_E000);
        prog_buf = '{addi(0, 0, 0), addi(0, 0, 0), u_type(rv_pkg::opc_auipc, 4, 'hFFFFF),
                     sw_word(4, 0, 'h100)};
        add_test("auipc", 32'hFFFF_F008);
        prog_buf = '{u_type(rv_pkg::opc_lui, 1, 'h89ABD), addi(1, 1, -'h211), sw_word(1, 0, 'h40),
                     i_type(rv_pkg::opc_load, 2, 2, 0, 'h40), sw_word(2, 0, 'h100)};
        add_test("sw_lw", 32'h89AB_CDEF);
        prog_buf = '{addi(0, 0, 55), addi(1, 0, 5), alu_rr(0, 0, 0, 1, 1), sw_word(0, 0, 'h100)};
        add_test("x0_write", 32'h0);
        prog_buf = '{addi(1, 0, 'h2A), sw_word(1, 0, 'h100), 32'hFFFF_FFFF, addi(1, 0, 1),
                     sw_word(1, 0, 'h100)};
        add_test("illegal_halt", 32'h2A);
    endtask

    task automatic check_value(input string name, input string what,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s %s: expected %h, actual %h", name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic run_test(input int t);
        int cycles;
        int errors_before;
        cycles        = 0;
        errors_before = errors;
        @(posedge clk);
        reset <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] <= 32'h5A00_0000 | (i << 2);    // fill tagged with byte address
        end
        for (int k = 0; k < 8; k++) begin
            mem[k] <= progs[t][k];
        end
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!halted && cycles < timeout_cyc);
        if (!halted) begin
            $display("ERROR: test %s: core never halted within %0d cycles", test_name[t],
                     timeout_cyc);
            errors++;
        end else begin
            check_value(test_name[t], "store address", exp_addr[t], last_addr);
            check_value(test_name[t], "store data", exp_data[t], last_data);
        end
        if (errors != errors_before) begin
            failed_tests++;
        end
        $display("test %-14s %s (%0d cycles)", test_name[t],
                 (errors == errors_before) ? "ok" : "FAIL", cycles);
    endtask

    initial begin
        void'($urandom(53));
        reset <= 1'b1;
        build_table();
        for (int t = 0; t < num_tests; t++) begin
            run_test(t);
        end
        if (uut.u_control.u_assertions.fail_count != 0) begin
            $display("ERROR: %0d bus or halt assertions failed during the run",
                     uut.u_control.u_assertions.fail_count);
            errors += uut.u_control.u_assertions.fail_count;
        end
        $display("tests run %0d, passed %0d, failed %0d, errors %0d", num_tests,
                 num_tests - failed_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_clock.sv
`default_nettype none

module tb_clock #(
    parameter realtime HALF_PERIOD = 2.0
) (
    output logic clk
);

    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
    end

    always #(HALF_PERIOD) clk = ~clk;   // 4 ns period

endmodule

`default_nettype wire
